// ==== logic/ntm_addressing.sv ====
// Addressing pipeline top level
// Gated interpolation followed by a three-tap circular shift
`timescale 1ns/1ps
`default_nettype none

module ntm_addressing (
  input  wire                               CLK,
  input  wire                               RST,
  // Control
  input  wire                               START,
  input  wire                               W_IN_ENABLE,
  output logic                              W_OUT_ENABLE,
  output logic                              READY,
  // Data
  input  ntm_addressing_pkg::gate_t         GATE_IN,
  input  ntm_addressing_pkg::shift_taps_t   TAPS_IN,
  input  ntm_addressing_pkg::weight_pair_t  W_IN,
  output ntm_addressing_pkg::weight_t       W_OUT
);

  ////////////////////
  // Signals
  ////////////////////

  // Strobes from the FSM
  logic load_params;
  logic write_enable;
  logic shift_enable;

  // Element position
  ntm_addressing_pkg::index_t index;
  logic                       last;

  // Datapath
  ntm_addressing_pkg::weight_t     gated;
  ntm_addressing_pkg::neighbours_t neighbours;

  ////////////////////
  // Control
  ////////////////////

  ntm_addressing_fsm u_fsm (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .W_IN_ENABLE  (W_IN_ENABLE),
    .last         (last),
    .load_params  (load_params),
    .write_enable (write_enable),
    .shift_enable (shift_enable),
    .READY        (READY)
  );

  // Shared by gather and shift
  ntm_element_counter u_counter (
    .CLK          (CLK),
    .RST          (RST),
    .write_enable (write_enable),
    .shift_enable (shift_enable),
    .index        (index),
    .last         (last)
  );

  ////////////////////
  // Datapath
  ////////////////////

  ntm_interpolation u_interpolation (
    .CLK         (CLK),
    .RST         (RST),
    .load_params (load_params),
    .GATE_IN     (GATE_IN),
    .W_IN        (W_IN),
    .gated       (gated)
  );

  ntm_weight_buffer u_buffer (
    .CLK          (CLK),
    .RST          (RST),
    .write_enable (write_enable),
    .index        (index),
    .gated        (gated),
    .neighbours   (neighbours)
  );

  ntm_shift_convolution u_convolution (
    .CLK          (CLK),
    .RST          (RST),
    .load_params  (load_params),
    .shift_enable (shift_enable),
    .TAPS_IN      (TAPS_IN),
    .neighbours   (neighbours),
    .W_OUT_ENABLE (W_OUT_ENABLE),
    .W_OUT        (W_OUT)
  );

endmodule

`default_nettype wire

// ==== logic/ntm_addressing_fsm.sv ====
// Addressing sequencer: idle, gather, shift, done
// Qualifies the external strobes and produces the READY pulse
`timescale 1ns/1ps
`default_nettype none

module ntm_addressing_fsm (
  input  wire  CLK,
  input  wire  RST,
  input  wire  START,
  input  wire  W_IN_ENABLE,
  input  wire  last,
  output logic load_params,
  output logic write_enable,
  output logic shift_enable,
  output logic READY
);

  ntm_addressing_pkg::addressing_state_t state;

  ////////////////////
  // Strobes
  ////////////////////

  // START only counts while idle
  assign load_params  = (state == ntm_addressing_pkg::STATE_IDLE) && START;

  // Input elements only count while gathering
  assign write_enable = (state == ntm_addressing_pkg::STATE_GATHER) && W_IN_ENABLE;

  // One output per cycle, no back-pressure
  assign shift_enable = (state == ntm_addressing_pkg::STATE_SHIFT);

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_addressing_pkg::STATE_IDLE;
      READY <= 1'b0;
    end else begin
      case (state)
        ntm_addressing_pkg::STATE_IDLE: begin
          // Gate and taps latch on this edge
          if (START) begin
            state <= ntm_addressing_pkg::STATE_GATHER;
          end
        end
        ntm_addressing_pkg::STATE_GATHER: begin
          // Element 7 written, counter wraps to 0
          if (write_enable && last) begin
            state <= ntm_addressing_pkg::STATE_SHIFT;
          end
        end
        ntm_addressing_pkg::STATE_SHIFT: begin
          // Output 7 registered on this edge
          if (last) begin
            state <= ntm_addressing_pkg::STATE_DONE;
          end
        end
        ntm_addressing_pkg::STATE_DONE: begin
          // First cycle carries the last output, second one READY
          READY <= ~READY;
          if (READY) begin
            state <= ntm_addressing_pkg::STATE_IDLE;
          end
        end
        default: begin
          state <= ntm_addressing_pkg::STATE_IDLE;
          READY <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/ntm_addressing_pkg.sv ====
// Shared widths, fixed-point constants and types for the addressing
// pipeline: weight, gate, tap and index types, the FSM state enum and
// the structs for input pairs, shift taps and buffer neighbours
`default_nettype none

package ntm_addressing_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int VECTOR_LENGTH = 8;
  localparam int INDEX_W       = 3;
  localparam int FRAC_W        = 8;
  localparam int FIXED_ONE     = 256;
  localparam int WEIGHT_W      = 16;
  // Gate and taps reach 1.0 inclusive, hence one extra bit
  localparam int GATE_W        = FRAC_W + 1;
  // Weight times gate or tap
  localparam int PRODUCT_W     = WEIGHT_W + GATE_W;
  // Room for three products
  localparam int ACC_W         = PRODUCT_W + 2;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [WEIGHT_W-1:0] weight_t;
  typedef logic [GATE_W-1:0]   gate_t;
  typedef logic [GATE_W-1:0]   tap_t;
  typedef logic [INDEX_W-1:0]  index_t;

  // One input element
  typedef struct packed {
    weight_t content;
    weight_t previous;
  } weight_pair_t;

  // Taps for elements j-1, j and j+1
  typedef struct packed {
    tap_t back;
    tap_t stay;
    tap_t ahead;
  } shift_taps_t;

  // Buffer reads around one index
  typedef struct packed {
    weight_t back;
    weight_t stay;
    weight_t ahead;
  } neighbours_t;

  typedef enum logic [1:0] {
    STATE_IDLE,
    STATE_GATHER,
    STATE_SHIFT,
    STATE_DONE
  } addressing_state_t;

endpackage

`default_nettype wire

// ==== logic/ntm_element_counter.sv ====
// Element index counter with last-element flag
// Advances on the gather write strobe and the shift strobe alike
`timescale 1ns/1ps
`default_nettype none

module ntm_element_counter (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         write_enable,
  input  wire                         shift_enable,
  output ntm_addressing_pkg::index_t  index,
  output logic                        last
);

  // Final element of the vector
  assign last = (index == ntm_addressing_pkg::index_t'(ntm_addressing_pkg::VECTOR_LENGTH - 1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index <= '0;
    end else if (write_enable || shift_enable) begin
      // Wrap so shift starts at element 0
      if (last) begin
        index <= '0;
      end else begin
        index <= index + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/ntm_interpolation.sv ====
// Gated interpolation of content and previous weightings
// Gate latched at start, each element formed combinationally
`timescale 1ns/1ps
`default_nettype none

module ntm_interpolation (
  input  wire                                CLK,
  input  wire                                RST,
  input  wire                                load_params,
  input  ntm_addressing_pkg::gate_t          GATE_IN,
  input  ntm_addressing_pkg::weight_pair_t   W_IN,
  output ntm_addressing_pkg::weight_t        gated
);

  ntm_addressing_pkg::gate_t gate_q;
  ntm_addressing_pkg::gate_t gate_inv;

  logic [ntm_addressing_pkg::PRODUCT_W-1:0] content_term;
  logic [ntm_addressing_pkg::PRODUCT_W-1:0] previous_term;
  logic [ntm_addressing_pkg::ACC_W-1:0]     sum;

  // Gate held for the whole run
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      gate_q <= '0;
    end else if (load_params) begin
      gate_q <= GATE_IN;
    end
  end

  // 1 - g in the same format
  assign gate_inv = ntm_addressing_pkg::gate_t'(ntm_addressing_pkg::FIXED_ONE) - gate_q;

  // g*wc and (1-g)*w(t-1)
  assign content_term  = W_IN.content * gate_q;
  assign previous_term = W_IN.previous * gate_inv;
  assign sum           = content_term + previous_term;

  // Drop fraction bits, result never exceeds 16 bits for gate up to 1.0
  assign gated = sum[ntm_addressing_pkg::FRAC_W +: ntm_addressing_pkg::WEIGHT_W];

endmodule

`default_nettype wire

// ==== logic/ntm_shift_convolution.sv ====
// Three-tap circular shift convolution with saturation
// Taps latched at start, one registered output per shift strobe
`timescale 1ns/1ps
`default_nettype none

module ntm_shift_convolution (
  input  wire                              CLK,
  input  wire                              RST,
  input  wire                              load_params,
  input  wire                              shift_enable,
  input  ntm_addressing_pkg::shift_taps_t  TAPS_IN,
  input  ntm_addressing_pkg::neighbours_t  neighbours,
  output logic                             W_OUT_ENABLE,
  output ntm_addressing_pkg::weight_t      W_OUT
);

  ntm_addressing_pkg::shift_taps_t taps_q;

  logic [ntm_addressing_pkg::PRODUCT_W-1:0] back_term;
  logic [ntm_addressing_pkg::PRODUCT_W-1:0] stay_term;
  logic [ntm_addressing_pkg::PRODUCT_W-1:0] ahead_term;
  logic [ntm_addressing_pkg::ACC_W-1:0]     acc;
  logic                                     overflow;
  ntm_addressing_pkg::weight_t              result;

  // Taps held for the whole run
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      taps_q <= '0;
    end else if (load_params) begin
      taps_q <= TAPS_IN;
    end
  end

  ////////////////////
  // Sum of products
  ////////////////////

  // s(j-1)*g(j-1) + s(j)*g(j) + s(j+1)*g(j+1)
  assign back_term  = neighbours.back * taps_q.back;
  assign stay_term  = neighbours.stay * taps_q.stay;
  assign ahead_term = neighbours.ahead * taps_q.ahead;
  assign acc        = back_term + stay_term + ahead_term;

  // Anything above bit 23 means the scaled sum exceeds 16 bits
  assign overflow = |acc[ntm_addressing_pkg::ACC_W-1:
                         ntm_addressing_pkg::FRAC_W + ntm_addressing_pkg::WEIGHT_W];

  // Clip to 65535
  assign result = overflow ? '1 : acc[ntm_addressing_pkg::FRAC_W +: ntm_addressing_pkg::WEIGHT_W];

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      W_OUT_ENABLE <= 1'b0;
      W_OUT        <= '0;
    end else begin
      W_OUT_ENABLE <= shift_enable;
      // Value holds between runs
      if (shift_enable) begin
        W_OUT <= result;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/ntm_weight_buffer.sv ====
// Register array for the gated weighting
// Circular back, stay and ahead reads around the current index
`timescale 1ns/1ps
`default_nettype none

module ntm_weight_buffer (
  input  wire                              CLK,
  input  wire                              RST,
  input  wire                              write_enable,
  input  ntm_addressing_pkg::index_t       index,
  input  ntm_addressing_pkg::weight_t      gated,
  output ntm_addressing_pkg::neighbours_t  neighbours
);

  ntm_addressing_pkg::weight_t weights [ntm_addressing_pkg::VECTOR_LENGTH];

  ntm_addressing_pkg::index_t back_index;
  ntm_addressing_pkg::index_t ahead_index;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < ntm_addressing_pkg::VECTOR_LENGTH; i++) begin
        weights[i] <= '0;
      end
    end else if (write_enable) begin
      weights[index] <= gated;
    end
  end

  ////////////////////
  // Circular reads
  ////////////////////

  // Element 0 looks back to element 7
  assign back_index  = (index == '0) ?
                       ntm_addressing_pkg::index_t'(ntm_addressing_pkg::VECTOR_LENGTH - 1) :
                       index - 1'b1;
  // Element 7 looks ahead to element 0
  assign ahead_index = (index == ntm_addressing_pkg::index_t'(ntm_addressing_pkg::VECTOR_LENGTH - 1)) ?
                       '0 : index + 1'b1;

  assign neighbours.back  = weights[back_index];
  assign neighbours.stay  = weights[index];
  assign neighbours.ahead = weights[ahead_index];

endmodule

`default_nettype wire

// ==== project.f ====
logic/ntm_addressing_pkg.sv
logic/ntm_element_counter.sv
logic/ntm_addressing_fsm.sv
logic/ntm_interpolation.sv
logic/ntm_weight_buffer.sv
logic/ntm_shift_convolution.sv
logic/ntm_addressing.sv
test/ntm_addressing_sva.sv
test/ntm_addressing_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the addressing testbench with Verilator
# The pass line in the log decides the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module ntm_addressing_tb -f project.f \
  --Mdir "$OBJ_DIR" -o Vntm_addressing_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$OBJ_DIR/Vntm_addressing_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== test/ntm_addressing_stimulus.txt ====
// Header: gate tap_back tap_stay tap_ahead, then eight rows: content previous gap
// (gap = idle cycles before that strobe), then the eight expected outputs; hex
// Pure content weighting
100 0 100 0
0100 0050 0
0200 3333 0
0080 7777 0
1234 0001 0
0000 abcd 0
ffff 0010 0
00ff 2222 0
8000 4444 0
0100 0200 0080 1234 0000 ffff 00ff 8000
// Pure previous weighting, with gaps
0 0 100 0
1111 0040 1
2222 0123 0
3333 0fff 2
4444 ffff 0
5555 7fff 0
6666 0002 3
7777 0900 0
8888 c000 1
0040 0123 0fff ffff 7fff 0002 0900 c000
// Gate 0.25, truncated sums
40 0 100 0
0100 0000 0
0000 0100 1
0003 0001 0
0400 0800 0
ffff ffff 2
1000 0000 0
0005 0007 0
00ff 0101 0
0040 00c0 0001 0700 ffff 0400 0006 0100
// Shift by one, element 0 takes element 7
100 100 0 0
a000 ffff 0
0011 ffff 0
0022 ffff 0
0033 ffff 0
0044 ffff 0
0055 ffff 0
0066 ffff 0
0077 ffff 0
0077 a000 0011 0022 0033 0044 0055 0066
// Shift the other way, with gaps
100 0 0 100
0100 5555 3
0200 5555 0
0300 5555 0
0400 5555 1
0500 5555 0
0600 5555 0
0700 5555 0
0800 5555 4
0200 0300 0400 0500 0600 0700 0800 0100
// Spread 0.5/1/0.5 with saturation
100 80 100 80
f000 1234 0
f000 1234 0
1000 1234 1
0000 1234 0
0010 1234 6
0003 1234 0
8000 1234 0
9000 1234 0
ffff ffff 8800 0808 0011 400b c801 ffff
// End of tests
ffffffff

// ==== test/ntm_addressing_sva.sv ====
// Timing assertions bound to the addressing top level
// Output run length, READY pulse shape and quiet outputs in reset
`timescale 1ns/1ps
`default_nettype none

module ntm_addressing_sva (
  input wire CLK,
  input wire RST,
  input wire W_OUT_ENABLE,
  input wire READY
);

  // Consecutive output cycles so far
  logic [3:0] run_length;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      run_length <= '0;
    end else if (W_OUT_ENABLE) begin
      run_length <= run_length + 4'd1;
    end else begin
      run_length <= '0;
    end
  end

  ////////////////////
  // Output run
  ////////////////////

  // Never a ninth output in a row
  run_not_too_long: assert property (
    @(posedge CLK) disable iff (RST) W_OUT_ENABLE |-> (run_length < 4'd8)
  ) else $error("more than eight consecutive output cycles");

  // Run ends after eight outputs, READY right behind it
  run_then_ready: assert property (
    @(posedge CLK) disable iff (RST)
    ($past(W_OUT_ENABLE) && !W_OUT_ENABLE) |-> (run_length == 4'd8 && READY)
  ) else $error("output run did not end with eight outputs and READY");

  ////////////////////
  // READY pulse
  ////////////////////

  // Only directly after an output cycle
  ready_after_output: assert property (
    @(posedge CLK) disable iff (RST) READY |-> $past(W_OUT_ENABLE)
  ) else $error("READY without a preceding output cycle");

  // Single cycle
  ready_one_cycle: assert property (
    @(posedge CLK) disable iff (RST) READY |=> !READY
  ) else $error("READY held longer than one cycle");

  // Both strobes quiet while in reset
  quiet_in_reset: assert property (
    @(posedge CLK) RST |-> (!W_OUT_ENABLE && !READY)
  ) else $error("output strobe high during reset");

endmodule

`default_nettype wire

// ==== test/ntm_addressing_tb.sv ====
// Testbench for the addressing pipeline
// Reads tests from the stimulus file, drives START and the input strobes,
// checks each output and the READY pulse, counts errors, watchdog timeout
`timescale 1ns/1ps
`default_nettype none

module ntm_addressing_tb;

  // Header, eight element rows of three words, eight expected outputs
  localparam int WORDS_PER_TEST    = 36;
  localparam int ELEMENT_BASE      = 4;
  localparam int EXPECTED_BASE     = 28;
  localparam int MAX_TESTS         = 16;
  localparam int MEM_WORDS         = WORDS_PER_TEST * MAX_TESTS + 4;
  // Cycles from the last input strobe to the first output, with slack
  localparam int OUTPUT_WAIT_LIMIT = 8;

  logic CLK;
  logic RST;
  logic START;
  logic W_IN_ENABLE;
  logic W_OUT_ENABLE;
  logic READY;

  ntm_addressing_pkg::gate_t        GATE_IN;
  ntm_addressing_pkg::shift_taps_t  TAPS_IN;
  ntm_addressing_pkg::weight_pair_t W_IN;
  ntm_addressing_pkg::weight_t      W_OUT;

  logic [31:0] stimulus [MEM_WORDS];

  int mismatch_count;
  int failure_count;
  int test_count;
  int max_gap;
  int cycle_count;
  int cycle_limit;
  bit limit_ready;

  ////////////////////
  // DUT
  ////////////////////

  ntm_addressing UUT (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .W_IN_ENABLE  (W_IN_ENABLE),
    .W_OUT_ENABLE (W_OUT_ENABLE),
    .READY        (READY),
    .GATE_IN      (GATE_IN),
    .TAPS_IN      (TAPS_IN),
    .W_IN         (W_IN),
    .W_OUT        (W_OUT)
  );

  bind ntm_addressing ntm_addressing_sva u_sva (
    .CLK          (CLK),
    .RST          (RST),
    .W_OUT_ENABLE (W_OUT_ENABLE),
    .READY        (READY)
  );

  // 10 ns clock
  initial begin
    CLK = 1'b0;
    forever begin
      #5 CLK = ~CLK;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic wait_drive_slot();
    @(posedge CLK);
    #1;
  endtask

  // Tests end at the first header whose gate is above 1.0
  task automatic count_tests();
    test_count = 0;
    max_gap = 0;
    while (test_count < MAX_TESTS &&
           stimulus[test_count * WORDS_PER_TEST] <= 32'(ntm_addressing_pkg::FIXED_ONE)) begin
      for (int e = 0; e < ntm_addressing_pkg::VECTOR_LENGTH; e++) begin
        if (int'(stimulus[test_count * WORDS_PER_TEST + ELEMENT_BASE + 3 * e + 2]) > max_gap) begin
          max_gap = int'(stimulus[test_count * WORDS_PER_TEST + ELEMENT_BASE + 3 * e + 2]);
        end
      end
      test_count++;
    end
  endtask

  // Gate and taps with a one-cycle START
  task automatic start_test(input int t);
    int base;
    base = t * WORDS_PER_TEST;
    GATE_IN       = ntm_addressing_pkg::gate_t'(stimulus[base]);
    TAPS_IN.back  = ntm_addressing_pkg::tap_t'(stimulus[base + 1]);
    TAPS_IN.stay  = ntm_addressing_pkg::tap_t'(stimulus[base + 2]);
    TAPS_IN.ahead = ntm_addressing_pkg::tap_t'(stimulus[base + 3]);
    START = 1'b1;
    wait_drive_slot();
    START = 1'b0;
    // Only the latched gate and taps may count from here on
    GATE_IN       = '1;
    TAPS_IN       = '1;
  endtask

  // Gap counts idle cycles ahead of each strobe
  task automatic send_elements(input int t);
    int base;
    int gap;
    base = t * WORDS_PER_TEST + ELEMENT_BASE;
    for (int e = 0; e < ntm_addressing_pkg::VECTOR_LENGTH; e++) begin
      gap = int'(stimulus[base + 3 * e + 2]);
      repeat (gap) wait_drive_slot();
      W_IN.content  = ntm_addressing_pkg::weight_t'(stimulus[base + 3 * e]);
      W_IN.previous = ntm_addressing_pkg::weight_t'(stimulus[base + 3 * e + 1]);
      W_IN_ENABLE   = 1'b1;
      wait_drive_slot();
      W_IN_ENABLE   = 1'b0;
      // Junk on the bus while no strobe
      W_IN          = '1;
    end
  endtask

  // Outputs sampled at the falling edge, mid cycle
  task automatic check_outputs(input int t);
    int base;
    int waited;
    int seen;
    ntm_addressing_pkg::weight_t expected;
    base = t * WORDS_PER_TEST + EXPECTED_BASE;
    waited = 0;
    seen = 0;
    @(negedge CLK);
    while (!W_OUT_ENABLE && waited < OUTPUT_WAIT_LIMIT) begin
      @(negedge CLK);
      waited++;
    end
    while (W_OUT_ENABLE && seen < ntm_addressing_pkg::VECTOR_LENGTH) begin
      expected = ntm_addressing_pkg::weight_t'(stimulus[base + seen]);
      if (W_OUT !== expected) begin
        $display("mismatch at %0t: W_OUT element %0d of test %0d expected %h got %h",
                 $time, seen, t, expected, W_OUT);
        mismatch_count++;
      end
      seen++;
      @(negedge CLK);
    end
    if (seen != ntm_addressing_pkg::VECTOR_LENGTH) begin
      $display("test %0d: only %0d of the eight outputs came out", t, seen);
      failure_count++;
    end else if (W_OUT_ENABLE || !READY) begin
      $display("test %0d: READY did not come right after the eighth output", t);
      failure_count++;
    end
  endtask

  task automatic finish_run();
    $display("mismatches: %0d, other errors: %0d", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    cycle_count = 0;
    wait (limit_ready);
    while (cycle_count < cycle_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    failure_count++;
    finish_run();
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    RST            = 1'b1;
    START          = 1'b0;
    W_IN_ENABLE    = 1'b0;
    GATE_IN        = '0;
    TAPS_IN        = '0;
    W_IN           = '0;
    mismatch_count = 0;
    failure_count  = 0;
    limit_ready    = 1'b0;
    // Address-tagged fill, every word above any legal gate
    for (int i = 0; i < MEM_WORDS; i++) begin
      stimulus[i] = 32'hF000_0000 | 32'(i);
    end
    $readmemh("test/ntm_addressing_stimulus.txt", stimulus);
    count_tests();
    cycle_limit = test_count * (8 * (max_gap + 1) + 20) + 50;
    limit_ready = 1'b1;
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b0;
    if (test_count == 0) begin
      $display("no tests found in the stimulus file");
      failure_count++;
    end
    // Back to back, next START in the cycle after READY
    for (int t = 0; t < test_count; t++) begin
      wait_drive_slot();
      start_test(t);
      send_elements(t);
      check_outputs(t);
    end
    finish_run();
  end

endmodule

`default_nettype wire
